//--- conv_afu_config.svh
`ifndef CONV_AFU_CONFIG_SVH
`define CONV_AFU_CONFIG_SVH

// host cacheline address and request tag widths
`define CL_ADDR_W 58
`define MDATA_W 14

// one cacheline carries eight complex elements of two 32-bit parts
`define CPLX_PER_CL 8
`define PART_W 32

// kernel store address bits for up to 16 input feature maps
`define KERN_DEPTH_BITS 4

// reads allowed in flight at once
`define MAX_OUTSTANDING 8

// output FIFO of 16 tiles
`define OUT_FIFO_DEPTH_BITS 4

// count at which the output FIFO reports almost full
`define OUT_FIFO_AF_LEVEL 8

`endif

//--- conv_afu_pkg.sv
`default_nettype none

`include "conv_afu_config.svh"

package conv_afu_pkg;

  // real part sits in the low half of the element
  typedef struct packed {
    logic [`PART_W-1:0] im;
    logic [`PART_W-1:0] re;
  } cplx_t;

  typedef cplx_t [`CPLX_PER_CL-1:0] cl_t;

  // kernel flag in bit 0 and kernel index above it
  typedef struct packed {
    logic [`MDATA_W-`KERN_DEPTH_BITS-2:0] spare;
    logic [`KERN_DEPTH_BITS-1:0]          kidx;
    logic                                 is_kernel;
  } mdata_t;

  typedef struct packed {
    logic                 en;
    logic [`CL_ADDR_W-1:0] addr;
    mdata_t               mdata;
  } rd_req_t;

  typedef struct packed {
    logic   valid;
    mdata_t mdata;
    cl_t    data;
  } rd_rsp_t;

  typedef struct packed {
    logic                 en;
    logic [`CL_ADDR_W-1:0] addr;
    cl_t                  data;
  } wr_req_t;

  // num_in holds 1 to 16 and needs the extra bit
  typedef struct packed {
    logic [`CL_ADDR_W-1:0]     filter_offset;
    logic [`CL_ADDR_W-1:0]     dest_offset;
    logic [`KERN_DEPTH_BITS:0] num_in;
    logic                      fence_en;
  } job_t;

endpackage

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_afu_config.svh"

module sync_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  depth_bits = `OUT_FIFO_DEPTH_BITS
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  logic     pop,
  input  payload_t din,
  output payload_t dout,
  output logic     empty,
  output logic     almost_full
);

  payload_t              mem [2**depth_bits];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [depth_bits:0]   count;
  logic                  do_push;
  logic                  do_pop;

  // top count bit set means full
  assign do_push = push && !count[depth_bits];
  assign do_pop = pop && !empty;
  assign empty = (count == '0);
  assign almost_full = (count >= (depth_bits + 1)'(`OUT_FIFO_AF_LEVEL));

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + do_push - do_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
    // dout holds until the next pop
    if (do_pop) dout <= mem[rd_ptr];
  end

endmodule

`default_nettype wire

//--- rd_req_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_afu_config.svh"

module rd_req_engine
  import conv_afu_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    go,
  input  job_t    job_q,
  input  logic    tiles_known,
  input  logic    rd_req_almostfull,
  input  logic    rsp_valid,
  input  logic    fifo_almost_full,
  output rd_req_t rd_req
);

  localparam int cnt_w = $clog2(`MAX_OUTSTANDING + 1);

  typedef enum logic [1:0] {st_idle, st_kernel, st_image} state_t;

  state_t                      state;
  logic [`CL_ADDR_W-1:0]       line_addr;
  logic [`KERN_DEPTH_BITS-1:0] kidx;
  logic [cnt_w-1:0]            outstanding;
  logic                        can_issue;
  logic                        issue;
  logic                        last_kernel;
  logic                        last_image;
  logic                        req_en;
  logic [`CL_ADDR_W-1:0]       req_addr;
  mdata_t                      req_mdata;

  // room on the host side and below the in-flight limit
  assign can_issue = tiles_known && !rd_req_almostfull &&
                     (outstanding < cnt_w'(`MAX_OUTSTANDING));
  // image lines also wait for space in the output FIFO
  assign issue = can_issue &&
                 ((state == st_kernel) || (state == st_image && !fifo_almost_full));
  assign last_kernel = ({1'b0, kidx} == job_q.num_in - 1'b1);
  assign last_image = (line_addr == job_q.filter_offset - 1'b1);

  assign rd_req = '{en: req_en, addr: req_addr, mdata: req_mdata};

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_idle;
      req_en      <= 1'b0;
      outstanding <= '0;
      kidx        <= '0;
      line_addr   <= '0;
    end else begin
      req_en <= issue;
      // in flight from the request until its response
      case ({issue, rsp_valid})
        2'b10: outstanding <= outstanding + 1'b1;
        2'b01: outstanding <= outstanding - 1'b1;
        default: ;
      endcase
      case (state)
        st_idle: begin
          if (go) begin
            kidx      <= '0;
            line_addr <= '0;
            state     <= st_kernel;
          end
        end
        st_kernel: begin
          if (issue) begin
            kidx <= kidx + 1'b1;
            if (last_kernel) begin
              state <= (job_q.filter_offset == '0) ? st_idle : st_image;
            end
          end
        end
        st_image: begin
          if (issue) begin
            line_addr <= line_addr + 1'b1;
            if (last_image) begin
              state <= st_idle;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      if (state == st_kernel) begin
        req_addr  <= job_q.filter_offset + `CL_ADDR_W'(kidx);
        req_mdata <= '{spare: '0, kidx: kidx, is_kernel: 1'b1};
      end else begin
        req_addr  <= line_addr;
        req_mdata <= '{spare: '0, kidx: '0, is_kernel: 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

//--- tile_mac.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_afu_config.svh"

module tile_mac
  import conv_afu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  go,
  input  job_t                  job_q,
  input  rd_rsp_t               rd_rsp,
  output logic                  push,
  output cl_t                   din,
  output logic [`CL_ADDR_W-1:0] tile_count_total,
  output logic                  tiles_known
);

  typedef enum logic [1:0] {div_idle, div_load, div_run} div_state_t;

  div_state_t                  div_state;
  logic [`CL_ADDR_W-1:0]       remainder;
  cl_t                         kern_mem [2**`KERN_DEPTH_BITS];
  cl_t                         kern_line;
  cl_t                         acc_sum;
  logic [`KERN_DEPTH_BITS-1:0] map_cnt;
  logic                        img_valid;
  logic                        last_map;

  assign img_valid = rd_rsp.valid && !rd_rsp.mdata.is_kernel;
  assign last_map = ({1'b0, map_cnt} == job_q.num_in - 1'b1);
  // image line d pairs with kernel line d
  assign kern_line = kern_mem[map_cnt];

  always_ff @(posedge clk) begin
    if (rd_rsp.valid && rd_rsp.mdata.is_kernel) begin
      kern_mem[rd_rsp.mdata.kidx] <= rd_rsp.data;
    end
  end

  // complex product per lane keeping the low 32 bits
  always_comb begin
    for (int l = 0; l < `CPLX_PER_CL; l++) begin
      acc_sum[l].re = rd_rsp.data[l].re * kern_line[l].re -
                      rd_rsp.data[l].im * kern_line[l].im;
      acc_sum[l].im = rd_rsp.data[l].re * kern_line[l].im +
                      rd_rsp.data[l].im * kern_line[l].re;
      // first map of a tile starts a fresh sum
      if (map_cnt != '0) begin
        acc_sum[l].re = acc_sum[l].re + din[l].re;
        acc_sum[l].im = acc_sum[l].im + din[l].im;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      push    <= 1'b0;
      map_cnt <= '0;
    end else begin
      push <= img_valid && last_map;
      if (go) begin
        map_cnt <= '0;
      end else if (img_valid) begin
        map_cnt <= last_map ? '0 : map_cnt + 1'b1;
      end
    end
  end

  // din doubles as the accumulator and is sampled by the FIFO on push
  always_ff @(posedge clk) begin
    if (img_valid) begin
      din <= acc_sum;
    end
  end

  // tile count by repeated subtraction of num_in
  always_ff @(posedge clk) begin
    if (reset) begin
      div_state   <= div_idle;
      tiles_known <= 1'b0;
    end else if (go) begin
      div_state   <= div_load;
      tiles_known <= 1'b0;
    end else begin
      case (div_state)
        div_load: begin
          remainder        <= job_q.filter_offset;
          tile_count_total <= '0;
          div_state        <= div_run;
        end
        div_run: begin
          if (remainder >= `CL_ADDR_W'(job_q.num_in)) begin
            remainder        <= remainder - `CL_ADDR_W'(job_q.num_in);
            tile_count_total <= tile_count_total + 1'b1;
          end else begin
            tiles_known <= 1'b1;
            div_state   <= div_idle;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- wr_req_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_afu_config.svh"

module wr_req_engine
  import conv_afu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  go,
  input  job_t                  job_q,
  input  logic [`CL_ADDR_W-1:0] tile_count_total,
  input  logic                  empty,
  input  cl_t                   dout,
  input  logic                  wr_req_almostfull,
  output logic                  pop,
  output wr_req_t               wr_req,
  output logic                  wr_fence_valid,
  output logic                  done
);

  localparam int cl_w = $bits(cl_t);

  typedef enum logic [2:0] {st_idle, st_pop, st_data, st_fence, st_flag} state_t;

  state_t                state;
  logic [`CL_ADDR_W-1:0] n;
  logic                  data_issue;
  logic                  fence_issue;
  logic                  flag_issue;
  logic                  last_tile;
  logic                  req_en;
  logic [`CL_ADDR_W-1:0] req_addr;
  cl_t                   req_data;

  assign pop = (state == st_pop) && !empty;
  assign data_issue = (state == st_data) && !wr_req_almostfull;
  assign fence_issue = (state == st_fence) && !wr_req_almostfull;
  assign flag_issue = (state == st_flag) && !wr_req_almostfull;
  assign last_tile = (n == tile_count_total);

  assign wr_req = '{en: req_en, addr: req_addr, data: req_data};

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= st_idle;
      req_en         <= 1'b0;
      wr_fence_valid <= 1'b0;
      done           <= 1'b0;
      n              <= '0;
    end else begin
      req_en         <= data_issue || flag_issue;
      wr_fence_valid <= fence_issue;
      case (state)
        st_idle: begin
          // final flag write went out last cycle
          if (req_en) done <= 1'b1;
          if (go) begin
            done  <= 1'b0;
            n     <= '0;
            state <= st_pop;
          end
        end
        st_pop: if (pop) state <= st_data;
        st_data: begin
          if (data_issue) begin
            n     <= n + 1'b1;
            state <= job_q.fence_en ? st_fence : st_flag;
          end
        end
        st_fence: if (fence_issue) state <= st_flag;
        st_flag: begin
          if (flag_issue) begin
            state <= last_tile ? st_idle : st_pop;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // tile n goes to dest_offset+n and the flag line carries n
  always_ff @(posedge clk) begin
    if (data_issue) begin
      req_addr <= job_q.dest_offset + n + 1'b1;
      req_data <= dout;
    end else if (flag_issue) begin
      req_addr <= job_q.dest_offset;
      req_data <= cl_t'(cl_w'(n));
    end
  end

endmodule

`default_nettype wire

//--- conv_afu.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_afu_config.svh"

module conv_afu
  import conv_afu_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    start,
  input  job_t    job,
  input  logic    rd_req_almostfull,
  input  rd_rsp_t rd_rsp,
  input  logic    wr_req_almostfull,
  output rd_req_t rd_req,
  output wr_req_t wr_req,
  output logic    wr_fence_valid,
  output logic    done
);

  logic                  busy;
  logic                  go;
  job_t                  job_q;
  logic                  tiles_known;
  logic [`CL_ADDR_W-1:0] tile_count_total;
  logic                  push;
  logic                  pop;
  cl_t                   fifo_din;
  cl_t                   fifo_dout;
  logic                  fifo_empty;
  logic                  fifo_almost_full;

  // a start during a running job is dropped
  assign go = start && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (go) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (go) job_q <= job;
  end

  rd_req_engine rd_req_engine_i (
    .clk              (clk),
    .reset            (reset),
    .go               (go),
    .job_q            (job_q),
    .tiles_known      (tiles_known),
    .rd_req_almostfull(rd_req_almostfull),
    .rsp_valid        (rd_rsp.valid),
    .fifo_almost_full (fifo_almost_full),
    .rd_req           (rd_req)
  );

  tile_mac tile_mac_i (
    .clk             (clk),
    .reset           (reset),
    .go              (go),
    .job_q           (job_q),
    .rd_rsp          (rd_rsp),
    .push            (push),
    .din             (fifo_din),
    .tile_count_total(tile_count_total),
    .tiles_known     (tiles_known)
  );

  sync_fifo #(
    .payload_t (cl_t),
    .depth_bits(`OUT_FIFO_DEPTH_BITS)
  ) out_fifo_i (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .pop        (pop),
    .din        (fifo_din),
    .dout       (fifo_dout),
    .empty      (fifo_empty),
    .almost_full(fifo_almost_full)
  );

  wr_req_engine wr_req_engine_i (
    .clk              (clk),
    .reset            (reset),
    .go               (go),
    .job_q            (job_q),
    .tile_count_total (tile_count_total),
    .empty            (fifo_empty),
    .dout             (fifo_dout),
    .wr_req_almostfull(wr_req_almostfull),
    .pop              (pop),
    .wr_req           (wr_req),
    .wr_fence_valid   (wr_fence_valid),
    .done             (done)
  );

endmodule

`default_nettype wire

//--- tb_conv_afu.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_afu_config.svh"

module tb_conv_afu
  import conv_afu_pkg::*;
();

  typedef struct {
    logic [`CL_ADDR_W-1:0] addr;
    mdata_t                mdata;
    int                    due;
  } pend_t;

  // one entry per write enable or fence pulse in bus order
  typedef struct packed {
    logic                  fence;
    logic [`CL_ADDR_W-1:0] addr;
    cl_t                   data;
  } wr_ev_t;

  logic    clk;
  logic    reset;
  logic    start;
  job_t    job;
  logic    rd_req_almostfull;
  rd_rsp_t rd_rsp;
  logic    wr_req_almostfull;
  rd_req_t rd_req;
  wr_req_t wr_req;
  logic    wr_fence_valid;
  logic    done;

  // image lines sit below filter_offset with the kernel lines right above
  cl_t     mem [64];
  pend_t   pending[$];
  rd_req_t rd_log[$];
  wr_ev_t  wr_log[$];

  int seed = 44;
  int cycle = 0;
  int pass_count = 0;
  int fail_count = 0;
  int writes_at_done = -1;
  logic prev_rd_af = 1'b0;
  logic prev_wr_af = 1'b0;
  logic prev_done = 1'b0;

  int job_fo[3] = '{14, 9, 35};
  int job_ni[3] = '{3, 1, 16};
  int job_dest[3] = '{100, 200, 300};
  bit job_fe[3] = '{1'b1, 1'b0, 1'b1};

  conv_afu conv_afu_i (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .job              (job),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp           (rd_rsp),
    .wr_req_almostfull(wr_req_almostfull),
    .rd_req           (rd_req),
    .wr_req           (wr_req),
    .wr_fence_valid   (wr_fence_valid),
    .done             (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(input string name, input logic [511:0] exp, input logic [511:0] act);
    if (exp !== act) begin
      fail_count++;
      $display("[ERROR] %s: expected %h, got %h", name, exp, act);
    end else begin
      pass_count++;
    end
  endtask

  // per-lane sum over d of image[t*ni+d] times kernel[d] with 32-bit wrap
  function automatic cl_t model_tile(input int fo, input int ni, input int t);
    cl_t   acc;
    cplx_t a;
    cplx_t b;
    acc = '0;
    for (int d = 0; d < ni; d++) begin
      for (int l = 0; l < `CPLX_PER_CL; l++) begin
        a = mem[6'(t * ni + d)][l];
        b = mem[6'(fo + d)][l];
        acc[l].re = acc[l].re + a.re * b.re - a.im * b.im;
        acc[l].im = acc[l].im + a.re * b.im + a.im * b.re;
      end
    end
    return acc;
  endfunction

  // host model drives its inputs 1 ns after the rising edge
  always @(posedge clk) begin
    #1;
    cycle++;
    rd_req_almostfull = (($random(seed) & 3) == 0);
    wr_req_almostfull = (($random(seed) & 3) == 0);
    if (pending.size() != 0 && pending[0].due <= cycle) begin
      rd_rsp.valid = 1'b1;
      rd_rsp.mdata = pending[0].mdata;
      rd_rsp.data = mem[pending[0].addr[5:0]];
      void'(pending.pop_front());
    end else begin
      rd_rsp.valid = 1'b0;
    end
  end

  // outputs are sampled on the falling edge
  always @(negedge clk) begin
    pend_t p;
    if (prev_rd_af) check("rd_req.en", 512'(0), 512'(rd_req.en));
    if (prev_wr_af) check("wr_req.en", 512'(0), 512'(wr_req.en));
    prev_rd_af = rd_req_almostfull;
    prev_wr_af = wr_req_almostfull;
    if (rd_req.en) begin
      rd_log.push_back(rd_req);
      p.addr = rd_req.addr;
      p.mdata = rd_req.mdata;
      // response comes 1 to 4 cycles later in request order
      p.due = cycle + 1 + int'($unsigned($random(seed)) % 4);
      pending.push_back(p);
    end
    if (wr_req.en) wr_log.push_back('{fence: 1'b0, addr: wr_req.addr, data: wr_req.data});
    if (wr_fence_valid) wr_log.push_back('{fence: 1'b1, addr: '0, data: '0});
    if (done && !prev_done) writes_at_done = wr_log.size();
    prev_done = done;
  end

  task automatic run_job(input int j);
    int fo;
    int ni;
    int tiles;
    int per_tile;
    int idx;
    int fences;
    int fails_before;
    fo = job_fo[j];
    ni = job_ni[j];
    tiles = fo / ni;
    per_tile = job_fe[j] ? 3 : 2;
    fails_before = fail_count;
    rd_log.delete();
    wr_log.delete();
    writes_at_done = -1;
    @(posedge clk);
    #1;
    job.filter_offset = `CL_ADDR_W'(fo);
    job.dest_offset = `CL_ADDR_W'(job_dest[j]);
    job.num_in = 5'(ni);
    job.fence_en = job_fe[j];
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    @(negedge clk);
    while (done !== 1'b1) @(negedge clk);
    // let leftover image reads drain before the next job
    repeat (20) @(negedge clk);
    while (pending.size() != 0) @(negedge clk);
    repeat (5) @(negedge clk);

    check("read count", 512'(fo + ni), 512'(rd_log.size()));
    if (rd_log.size() == fo + ni) begin
      for (int i = 0; i < fo + ni; i++) begin
        if (i < ni) begin
          check("rd_req.addr", 512'(fo + i), 512'(rd_log[i].addr));
          check("rd_req.mdata.is_kernel", 512'(1), 512'(rd_log[i].mdata.is_kernel));
          check("rd_req.mdata.kidx", 512'(i), 512'(rd_log[i].mdata.kidx));
        end else begin
          check("rd_req.addr", 512'(i - ni), 512'(rd_log[i].addr));
          check("rd_req.mdata.is_kernel", 512'(0), 512'(rd_log[i].mdata.is_kernel));
        end
      end
    end

    fences = 0;
    foreach (wr_log[i]) begin
      if (wr_log[i].fence) fences++;
    end
    check("wr_fence_valid count", 512'(job_fe[j] ? tiles : 0), 512'(fences));
    check("write event count", 512'(tiles * per_tile), 512'(wr_log.size()));
    // no write may follow the rise of done
    check("write events at done", 512'(wr_log.size()), 512'(writes_at_done));
    check("done", 512'(1), 512'(done));
    if (wr_log.size() == tiles * per_tile) begin
      idx = 0;
      for (int n = 1; n <= tiles; n++) begin
        check("wr_req.en", 512'(0), 512'(wr_log[idx].fence));
        check("wr_req.addr", 512'(job_dest[j] + n), 512'(wr_log[idx].addr));
        check("wr_req.data", model_tile(fo, ni, n - 1), wr_log[idx].data);
        idx++;
        if (job_fe[j]) begin
          check("wr_fence_valid", 512'(1), 512'(wr_log[idx].fence));
          idx++;
        end
        check("wr_req.en", 512'(0), 512'(wr_log[idx].fence));
        check("wr_req.addr", 512'(job_dest[j]), 512'(wr_log[idx].addr));
        check("wr_req.data", 512'(n), wr_log[idx].data);
        idx++;
      end
    end
    $display("job %0d (num_in %0d, %0d tiles): %0d errors",
             j, ni, tiles, fail_count - fails_before);
  endtask

  // watchdog scaled by the number of lines read in all jobs
  initial begin
    int lines;
    lines = 0;
    for (int j = 0; j < 3; j++) lines += job_fo[j] + job_ni[j];
    repeat (200 + 20 * lines) @(posedge clk);
    $display("timeout, the jobs did not complete within %0d cycles", 200 + 20 * lines);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int fails_before;
    reset = 1'b1;
    start = 1'b0;
    job = '0;
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp = '0;
    for (int a = 0; a < 64; a++) begin
      for (int l = 0; l < `CPLX_PER_CL; l++) begin
        mem[a][l].re = $random(seed);
        mem[a][l].im = $random(seed);
      end
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    fails_before = fail_count;
    repeat (3) begin
      @(negedge clk);
      check("rd_req.en", 512'(0), 512'(rd_req.en));
      check("wr_req.en", 512'(0), 512'(wr_req.en));
      check("wr_fence_valid", 512'(0), 512'(wr_fence_valid));
      check("done", 512'(0), 512'(done));
    end
    $display("idle after reset: %0d errors", fail_count - fails_before);

    for (int j = 0; j < 3; j++) run_job(j);

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
conv_afu_pkg.sv
sync_fifo.sv
rd_req_engine.sv
tile_mac.sv
wr_req_engine.sv
conv_afu.sv
tb_conv_afu.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module conv_afu

sim:
	verilator --binary --timing -f build.f --top-module tb_conv_afu -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
